//--- include/cpu_settings.svh
// widths, memory sizes and encodings shared by the core and the testbench
// opcodes and funct codes follow the MIPS-I encoding of the supported subset
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_XLEN        32
`define CPU_REG_AW      5
`define CPU_IMEM_DEPTH  64
`define CPU_DMEM_DEPTH  64
`define CPU_IMEM_AW     6

`define CPU_OP_RTYPE    6'h00
`define CPU_OP_ADDI     6'h08
`define CPU_OP_LW       6'h23
`define CPU_OP_SW       6'h2b
`define CPU_OP_BEQ      6'h04
`define CPU_OP_BNE      6'h05
`define CPU_OP_J        6'h02

`define CPU_FN_ADD      6'h20
`define CPU_FN_SUB      6'h22
`define CPU_FN_AND      6'h24
`define CPU_FN_OR       6'h25
`define CPU_FN_SLT      6'h2a

`define CPU_ALU_ADD     3'd0
`define CPU_ALU_SUB     3'd1
`define CPU_ALU_AND     3'd2
`define CPU_ALU_OR      3'd3
`define CPU_ALU_SLT     3'd4

`endif

//--- hw/cpu_pkg.sv
// instruction word layouts, one 32-bit word seen as R, I or J format
`include "cpu_settings.svh"

package cpu_pkg;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`CPU_REG_AW-1:0] rs;
        logic [`CPU_REG_AW-1:0] rt;
        logic [`CPU_REG_AW-1:0] rd;
        logic [4:0]             shamt;  // unused by the subset
        logic [5:0]             funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`CPU_REG_AW-1:0] rs;
        logic [`CPU_REG_AW-1:0] rt;
        logic [15:0]            imm;    // signed offset or constant
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;             // word index inside the 256 MB region
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

endpackage

//--- hw/fetch_unit.sv
// program counter and instruction memory
// load port writes only while the core is held in reset
`timescale 1ns/10ps
`include "cpu_settings.svh"

module fetch_unit (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  logic                    stall,
    input  logic                    pc_redirect,
    input  logic [`CPU_XLEN-1:0]    redirect_pc,
    input  logic                    load_en,
    input  logic [`CPU_IMEM_AW-1:0] load_addr,
    input  logic [`CPU_XLEN-1:0]    load_data,
    output logic [`CPU_XLEN-1:0]    f_instr,
    output logic [`CPU_XLEN-1:0]    f_pc
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] imem [0:`CPU_IMEM_DEPTH-1];

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= '0;
        else if (stall)
            pc <= pc;                       // decode is waiting
        else if (pc_redirect)
            pc <= redirect_pc;              // taken branch or jump, delay slot already fetched
        else
            pc <= pc + `CPU_XLEN'd4;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (load_en)
            imem[load_addr] <= load_data;
    end

    // word addressed, upper pc bits ignored
    assign f_instr = imem[pc[`CPU_IMEM_AW+1:2]];
    assign f_pc    = pc;

endmodule

//--- hw/reg_file.sv
// 32 x 32 register file, register 0 always reads zero
// a read of the register written this cycle returns the new value
`timescale 1ns/10ps
`include "cpu_settings.svh"

module reg_file (
    input  logic                   SYS_clk,
    input  logic [`CPU_REG_AW-1:0] rs_addr,
    input  logic [`CPU_REG_AW-1:0] rt_addr,
    input  logic                   wb_en,
    input  logic [`CPU_REG_AW-1:0] wb_reg,
    input  logic [`CPU_XLEN-1:0]   wb_data,
    output logic [`CPU_XLEN-1:0]   rs_val,
    output logic [`CPU_XLEN-1:0]   rt_val
);

    logic [`CPU_XLEN-1:0] regs [0:(1<<`CPU_REG_AW)-1];

    function automatic logic [`CPU_XLEN-1:0] read_port(input logic [`CPU_REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wb_en && (wb_reg == addr))
            return wb_data;                 // bypass the write in flight
        else
            return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (wb_en && (wb_reg != '0))
            regs[wb_reg] <= wb_data;
    end

    always_comb
    begin
        rs_val = read_port(rs_addr);
        rt_val = read_port(rt_addr);
    end

endmodule

//--- hw/decode_stage.sv
// decode register, register reads with forwarding from memory, branch resolution
// branches and jumps redirect fetch from here, so one delay slot always runs
`timescale 1ns/10ps
`include "cpu_settings.svh"

module decode_stage (
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic                   stall,
    input  logic [`CPU_XLEN-1:0]   f_instr,
    input  logic [`CPU_XLEN-1:0]   f_pc,
    input  logic                   fwd_rs,
    input  logic                   fwd_rt,
    input  logic [`CPU_XLEN-1:0]   mem_fwd_val,
    input  logic                   wb_en,
    input  logic [`CPU_REG_AW-1:0] wb_reg,
    input  logic [`CPU_XLEN-1:0]   wb_data,
    output cpu_pkg::instr_t        d_instr,
    output logic [`CPU_XLEN-1:0]   d_rs_val,
    output logic [`CPU_XLEN-1:0]   d_rt_val,
    output logic [`CPU_REG_AW-1:0] d_dest,
    output logic                   d_reg_write,
    output logic                   pc_redirect,
    output logic [`CPU_XLEN-1:0]   redirect_pc
);

    logic [`CPU_XLEN-1:0] d_pc;
    logic [`CPU_XLEN-1:0] rf_rs_val;
    logic [`CPU_XLEN-1:0] rf_rt_val;
    logic [`CPU_XLEN-1:0] br_offset;
    logic [`CPU_XLEN-1:0] br_target;
    logic [`CPU_XLEN-1:0] j_target;
    logic                 is_rtype;
    logic                 is_addi;
    logic                 is_lw;
    logic                 is_beq;
    logic                 is_bne;
    logic                 is_j;
    logic                 operands_eq;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            d_instr <= '0;                  // nop
            d_pc    <= '0;
        end
        else if (!stall)
        begin
            d_instr <= f_instr;
            d_pc    <= f_pc;
        end
    end

    reg_file i_reg_file (
        .SYS_clk (SYS_clk),
        .rs_addr (d_instr.r.rs),
        .rt_addr (d_instr.r.rt),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_data (wb_data),
        .rs_val  (rf_rs_val),
        .rt_val  (rf_rt_val)
    );

    assign is_rtype = (d_instr.r.opcode == `CPU_OP_RTYPE);
    assign is_addi  = (d_instr.r.opcode == `CPU_OP_ADDI);
    assign is_lw    = (d_instr.r.opcode == `CPU_OP_LW);
    assign is_beq   = (d_instr.r.opcode == `CPU_OP_BEQ);
    assign is_bne   = (d_instr.r.opcode == `CPU_OP_BNE);
    assign is_j     = (d_instr.r.opcode == `CPU_OP_J);

    assign d_dest      = is_rtype ? d_instr.r.rd : d_instr.i.rt;   // rd for R, rt for I
    assign d_reg_write = is_rtype | is_addi | is_lw;

    // memory stage result overrides the file
    assign d_rs_val = fwd_rs ? mem_fwd_val : rf_rs_val;
    assign d_rt_val = fwd_rt ? mem_fwd_val : rf_rt_val;

    assign operands_eq = (d_rs_val == d_rt_val);

    assign br_offset = {{(`CPU_XLEN-18){d_instr.i.imm[15]}}, d_instr.i.imm, 2'b00};
    assign br_target = d_pc + `CPU_XLEN'd4 + br_offset;             // relative to delay slot
    assign j_target  = {d_pc[31:28], d_instr.j.index, 2'b00};

    assign pc_redirect = is_j | (is_beq & operands_eq) | (is_bne & ~operands_eq);
    assign redirect_pc = is_j ? j_target : br_target;

endmodule

//--- hw/hazard_unit.sv
// one-cycle stall on a writer in execute, forward select on a writer in memory
// writers of register 0 never stall or forward
`timescale 1ns/10ps
`include "cpu_settings.svh"

module hazard_unit (
    input  cpu_pkg::instr_t        d_instr,
    input  logic [`CPU_REG_AW-1:0] ex_dest,
    input  logic                   ex_reg_write,
    input  logic [`CPU_REG_AW-1:0] mem_dest,
    input  logic                   mem_reg_write,
    output logic                   stall,
    output logic                   fwd_rs,
    output logic                   fwd_rt
);

    logic uses_rs;
    logic uses_rt;

    // true when a writer targets a source decode actually reads
    function automatic logic hits(input logic                   we,
                                  input logic [`CPU_REG_AW-1:0] dest,
                                  input logic                   used,
                                  input logic [`CPU_REG_AW-1:0] src);
        return we && (dest != '0) && used && (dest == src);
    endfunction

    assign uses_rs = (d_instr.r.opcode != `CPU_OP_J);
    assign uses_rt = (d_instr.r.opcode == `CPU_OP_RTYPE) ||
                     (d_instr.r.opcode == `CPU_OP_SW)    ||
                     (d_instr.r.opcode == `CPU_OP_BEQ)   ||
                     (d_instr.r.opcode == `CPU_OP_BNE);

    // loads stall here too, their data is ready one stage later
    assign stall = hits(ex_reg_write, ex_dest, uses_rs, d_instr.r.rs) ||
                   hits(ex_reg_write, ex_dest, uses_rt, d_instr.r.rt);

    assign fwd_rs = hits(mem_reg_write, mem_dest, uses_rs, d_instr.r.rs);
    assign fwd_rt = hits(mem_reg_write, mem_dest, uses_rt, d_instr.r.rt);

endmodule

//--- hw/execute_stage.sv
// execute register and ALU
// a stall loads a nop bubble; ALU ops other than the five supported fall back to add
`timescale 1ns/10ps
`include "cpu_settings.svh"

module execute_stage (
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic                   stall,
    input  cpu_pkg::instr_t        d_instr,
    input  logic [`CPU_XLEN-1:0]   d_rs_val,
    input  logic [`CPU_XLEN-1:0]   d_rt_val,
    input  logic [`CPU_REG_AW-1:0] d_dest,
    input  logic                   d_reg_write,
    output cpu_pkg::instr_t        ex_instr,
    output logic [`CPU_XLEN-1:0]   ex_result,
    output logic [`CPU_XLEN-1:0]   ex_store_val,
    output logic [`CPU_REG_AW-1:0] ex_dest,
    output logic                   ex_reg_write
);

    logic [`CPU_XLEN-1:0] ex_rs_val;
    logic [`CPU_XLEN-1:0] alu_b;
    logic [2:0]           alu_op;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
        begin
            ex_instr     <= '0;             // bubble
            ex_dest      <= '0;
            ex_reg_write <= 1'b0;
        end
        else
        begin
            ex_instr     <= d_instr;
            ex_dest      <= d_dest;
            ex_reg_write <= d_reg_write;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_rs_val    <= d_rs_val;
        ex_store_val <= d_rt_val;           // also the second ALU operand for R-type
    end

    always_comb
    begin
        alu_op = `CPU_ALU_ADD;              // addi, lw, sw address
        if (ex_instr.r.opcode == `CPU_OP_RTYPE)
        begin
            case (ex_instr.r.funct)
                `CPU_FN_SUB: alu_op = `CPU_ALU_SUB;
                `CPU_FN_AND: alu_op = `CPU_ALU_AND;
                `CPU_FN_OR:  alu_op = `CPU_ALU_OR;
                `CPU_FN_SLT: alu_op = `CPU_ALU_SLT;
                default:     alu_op = `CPU_ALU_ADD;
            endcase
        end
    end

    assign alu_b = (ex_instr.r.opcode == `CPU_OP_RTYPE) ? ex_store_val :
                   {{(`CPU_XLEN-16){ex_instr.i.imm[15]}}, ex_instr.i.imm};

    always_comb
    begin
        case (alu_op)
            `CPU_ALU_SUB: ex_result = ex_rs_val - alu_b;
            `CPU_ALU_AND: ex_result = ex_rs_val & alu_b;
            `CPU_ALU_OR:  ex_result = ex_rs_val | alu_b;
            `CPU_ALU_SLT: ex_result = {{(`CPU_XLEN-1){1'b0}},
                                       ($signed(ex_rs_val) < $signed(alu_b))};
            default:      ex_result = ex_rs_val + alu_b;
        endcase
    end

endmodule

//--- hw/mem_wb_stage.sv
// memory register with data memory, then the writeback register
// data memory is word addressed, low address bits ignored, not cleared by reset
`timescale 1ns/10ps
`include "cpu_settings.svh"

module mem_wb_stage (
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  cpu_pkg::instr_t        ex_instr,
    input  logic [`CPU_XLEN-1:0]   ex_result,
    input  logic [`CPU_XLEN-1:0]   ex_store_val,
    input  logic [`CPU_REG_AW-1:0] ex_dest,
    input  logic                   ex_reg_write,
    output logic [`CPU_REG_AW-1:0] mem_dest,
    output logic                   mem_reg_write,
    output logic [`CPU_XLEN-1:0]   mem_fwd_val,
    output logic                   wb_en,
    output logic [`CPU_REG_AW-1:0] wb_reg,
    output logic [`CPU_XLEN-1:0]   wb_data
);

    localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

    logic                 mem_lw;
    logic                 mem_sw;
    logic [`CPU_XLEN-1:0] mem_result;
    logic [`CPU_XLEN-1:0] mem_store_val;
    logic [`CPU_XLEN-1:0] mem_rd_data;
    logic [`CPU_XLEN-1:0] dmem [0:`CPU_DMEM_DEPTH-1];

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_lw        <= 1'b0;
            mem_sw        <= 1'b0;
            mem_dest      <= '0;
            mem_reg_write <= 1'b0;
        end
        else
        begin
            mem_lw        <= (ex_instr.r.opcode == `CPU_OP_LW);
            mem_sw        <= (ex_instr.r.opcode == `CPU_OP_SW);
            mem_dest      <= ex_dest;
            mem_reg_write <= ex_reg_write;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_result    <= ex_result;
        mem_store_val <= ex_store_val;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (mem_sw)
            dmem[mem_result[DMEM_AW+1:2]] <= mem_store_val;
    end

    assign mem_rd_data = dmem[mem_result[DMEM_AW+1:2]];           // combinational read
    assign mem_fwd_val = mem_lw ? mem_rd_data : mem_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            wb_en <= 1'b0;
        else
            wb_en <= mem_reg_write && (mem_dest != '0);          // writes to r0 dropped here
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_reg  <= mem_dest;
        wb_data <= mem_fwd_val;
    end

endmodule

//--- hw/mips_core.sv
// five-stage core, fetch / decode / execute / memory / writeback
// instruction memory must be loaded while SYS_reset is high
`timescale 1ns/10ps
`include "cpu_settings.svh"

module mips_core (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  logic                    load_en,
    input  logic [`CPU_IMEM_AW-1:0] load_addr,
    input  logic [`CPU_XLEN-1:0]    load_data,
    output logic                    wb_en,
    output logic [`CPU_REG_AW-1:0]  wb_reg,
    output logic [`CPU_XLEN-1:0]    wb_data
);

    logic [`CPU_XLEN-1:0]   f_instr;
    logic [`CPU_XLEN-1:0]   f_pc;
    logic                   pc_redirect;
    logic [`CPU_XLEN-1:0]   redirect_pc;
    logic                   stall;
    logic                   fwd_rs;
    logic                   fwd_rt;
    cpu_pkg::instr_t        d_instr;
    logic [`CPU_XLEN-1:0]   d_rs_val;
    logic [`CPU_XLEN-1:0]   d_rt_val;
    logic [`CPU_REG_AW-1:0] d_dest;
    logic                   d_reg_write;
    cpu_pkg::instr_t        ex_instr;
    logic [`CPU_XLEN-1:0]   ex_result;
    logic [`CPU_XLEN-1:0]   ex_store_val;
    logic [`CPU_REG_AW-1:0] ex_dest;
    logic                   ex_reg_write;
    logic [`CPU_REG_AW-1:0] mem_dest;
    logic                   mem_reg_write;
    logic [`CPU_XLEN-1:0]   mem_fwd_val;

    fetch_unit i_fetch_unit (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .stall       (stall),
        .pc_redirect (pc_redirect),
        .redirect_pc (redirect_pc),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .f_instr     (f_instr),
        .f_pc        (f_pc)
    );

    decode_stage i_decode_stage (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .stall       (stall),
        .f_instr     (f_instr),
        .f_pc        (f_pc),
        .fwd_rs      (fwd_rs),
        .fwd_rt      (fwd_rt),
        .mem_fwd_val (mem_fwd_val),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .d_instr     (d_instr),
        .d_rs_val    (d_rs_val),
        .d_rt_val    (d_rt_val),
        .d_dest      (d_dest),
        .d_reg_write (d_reg_write),
        .pc_redirect (pc_redirect),
        .redirect_pc (redirect_pc)
    );

    hazard_unit i_hazard_unit (
        .d_instr       (d_instr),
        .ex_dest       (ex_dest),
        .ex_reg_write  (ex_reg_write),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .stall         (stall),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt)
    );

    execute_stage i_execute_stage (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .stall        (stall),
        .d_instr      (d_instr),
        .d_rs_val     (d_rs_val),
        .d_rt_val     (d_rt_val),
        .d_dest       (d_dest),
        .d_reg_write  (d_reg_write),
        .ex_instr     (ex_instr),
        .ex_result    (ex_result),
        .ex_store_val (ex_store_val),
        .ex_dest      (ex_dest),
        .ex_reg_write (ex_reg_write)
    );

    mem_wb_stage i_mem_wb_stage (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .ex_instr      (ex_instr),
        .ex_result     (ex_result),
        .ex_store_val  (ex_store_val),
        .ex_dest       (ex_dest),
        .ex_reg_write  (ex_reg_write),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .mem_fwd_val   (mem_fwd_val),
        .wb_en         (wb_en),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data)
    );

endmodule

//--- bench/clock_gen.sv
// 20 ns clock and synchronous reset
// reset stays high while hold is high and for 16 more cycles after it drops
`timescale 1ns/10ps

module clock_gen (
    input  logic hold,
    output logic SYS_clk,
    output logic SYS_reset
);

    logic [4:0] held_cycles;

    initial
    begin
        SYS_clk = 1'b0;
    end

    always #10 SYS_clk = ~SYS_clk;

    always_ff @(posedge SYS_clk)
    begin
        if (hold)
            held_cycles <= '0;
        else if (held_cycles < 5'd16)
            held_cycles <= held_cycles + 5'd1;
    end

    assign SYS_reset = hold || (held_cycles < 5'd16);

endmodule

//--- bench/wb_checker.sv
// compares writeback events in order against the list given on start
// samples on the falling edge, where the DUT outputs are settled
`timescale 1ns/10ps
`include "cpu_settings.svh"

module wb_checker (
    input  logic                            SYS_clk,
    input  logic                            wb_en,
    input  logic [`CPU_REG_AW-1:0]          wb_reg,
    input  logic [`CPU_XLEN-1:0]            wb_data,
    input  logic                            start,
    input  logic                            report,
    input  logic [2:0]                      test_id,
    input  logic [3:0]                      exp_count,
    input  logic [5:0][`CPU_REG_AW-1:0]     exp_reg,
    input  logic [5:0][`CPU_XLEN-1:0]       exp_val,
    output logic                            done,
    output int                              failed_tests
);

    int tests_run;
    int total_errors;

    task automatic check_test();
        int   idx;
        int   waited;
        int   errs;
        logic arrived;
        done = 1'b0;
        errs = 0;
        for (idx = 0; idx < int'(exp_count); idx++)
        begin
            arrived = 1'b0;
            for (waited = 0; (waited < 200) && !arrived; waited++)
            begin
                @(negedge SYS_clk);
                arrived = wb_en;
            end
            if (!arrived)
            begin
                $display("test %0d: write %0d to register %0d never arrived within 200 cycles",
                         test_id, idx, exp_reg[idx]);
                errs++;
                break;
            end
            if (wb_reg !== exp_reg[idx])
            begin
                $display("FAILED test %0d write %0d: wb_reg 0x%h, expected 0x%h",
                         test_id, idx, wb_reg, exp_reg[idx]);
                errs++;
            end
            if (wb_data !== exp_val[idx])
            begin
                $display("FAILED test %0d write %0d: wb_data 0x%h, expected 0x%h",
                         test_id, idx, wb_data, exp_val[idx]);
                errs++;
            end
        end
        // program spins on its final jump, nothing more may write
        for (waited = 0; waited < 40; waited++)
        begin
            @(negedge SYS_clk);
            if (wb_en)
            begin
                $display("test %0d: unexpected extra write to register %0d", test_id, wb_reg);
                errs++;
            end
        end
        tests_run++;
        total_errors += errs;
        if (errs == 0)
            $display("test %0d passed, %0d writes checked", test_id, exp_count);
        else
        begin
            $display("test %0d failed with %0d errors", test_id, errs);
            failed_tests++;
        end
        done = 1'b1;
    endtask

    initial
    begin
        done         = 1'b1;
        failed_tests = 0;
        tests_run    = 0;
        total_errors = 0;
        forever
        begin
            @(negedge SYS_clk);
            if (start)
                check_test();
            else if (report)
                $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                         tests_run, tests_run - failed_tests, failed_tests, total_errors);
        end
    end

endmodule

//--- bench/tb_mips_core.sv
// five small programs, each loaded through the load port during reset
// each ends in a jump to itself so writeback goes quiet
`timescale 1ns/10ps
`include "cpu_settings.svh"

module tb_mips_core;

    logic                           hold;
    logic                           SYS_clk;
    logic                           SYS_reset;
    logic                           load_en;
    logic [`CPU_IMEM_AW-1:0]        load_addr;
    logic [`CPU_XLEN-1:0]           load_data;
    logic                           wb_en;
    logic [`CPU_REG_AW-1:0]         wb_reg;
    logic [`CPU_XLEN-1:0]           wb_data;
    logic                           start;
    logic                           report;
    logic [2:0]                     cur_test;
    logic [3:0]                     cur_count;
    logic [5:0][`CPU_REG_AW-1:0]    cur_reg;
    logic [5:0][`CPU_XLEN-1:0]      cur_val;
    logic                           checker_done;
    int                             failed_tests;
    logic                           timed_out;

    logic [`CPU_XLEN-1:0]   prog [0:4][0:9];
    int                     exp_n [0:4];
    logic [`CPU_REG_AW-1:0] exp_reg [0:4][0:5];
    logic [`CPU_XLEN-1:0]   exp_val [0:4][0:5];

    clock_gen i_clock_gen (.hold(hold), .SYS_clk(SYS_clk), .SYS_reset(SYS_reset));

    mips_core i_mips_core (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    wb_checker i_wb_checker (
        .SYS_clk      (SYS_clk),
        .wb_en        (wb_en),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .start        (start),
        .report       (report),
        .test_id      (cur_test),
        .exp_count    (cur_count),
        .exp_reg      (cur_reg),
        .exp_val      (cur_val),
        .done         (checker_done),
        .failed_tests (failed_tests)
    );

    function automatic logic [31:0] rtype_word(input int rd, input int rs, input int rt,
                                               input logic [5:0] fn);
        return {`CPU_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input int rt,
                                               input int rs, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] jump_word(input int index);
        return {`CPU_OP_J, index[25:0]};
    endfunction

    task automatic expect_write(input int t, input int r, input logic [31:0] v);
        exp_reg[t][exp_n[t]] = r[4:0];
        exp_val[t][exp_n[t]] = v;
        exp_n[t]++;
    endtask

    task automatic build_table();
        int t;
        int w;
        for (t = 0; t < 5; t++)
        begin
            exp_n[t] = 0;
            for (w = 0; w < 10; w++)
                prog[t][w] = '0;            // nop
            for (w = 0; w < 6; w++)
            begin
                exp_reg[t][w] = '0;
                exp_val[t][w] = '0;
            end
        end
        // ALU ops, negative operand from sub
        prog[0][0] = itype_word(`CPU_OP_ADDI, 1, 0, 12);
        prog[0][1] = rtype_word(2, 0, 1, `CPU_FN_SUB);
        prog[0][2] = rtype_word(3, 1, 1, `CPU_FN_ADD);
        prog[0][3] = rtype_word(4, 2, 3, `CPU_FN_AND);
        prog[0][4] = rtype_word(5, 1, 3, `CPU_FN_OR);
        prog[0][5] = rtype_word(6, 2, 1, `CPU_FN_SLT);
        prog[0][6] = jump_word(6);
        expect_write(0, 1, 32'h0000_000c);
        expect_write(0, 2, 32'hffff_fff4);
        expect_write(0, 3, 32'h0000_0018);
        expect_write(0, 4, 32'h0000_0010);
        expect_write(0, 5, 32'h0000_001c);
        expect_write(0, 6, 32'h0000_0001);
        // dependent chain
        prog[1][0] = itype_word(`CPU_OP_ADDI, 1, 0, 3);
        prog[1][1] = rtype_word(2, 1, 1, `CPU_FN_ADD);
        prog[1][2] = rtype_word(3, 2, 1, `CPU_FN_ADD);
        prog[1][3] = itype_word(`CPU_OP_ADDI, 4, 3, 100);
        prog[1][4] = rtype_word(5, 4, 2, `CPU_FN_SUB);
        prog[1][5] = rtype_word(6, 5, 5, `CPU_FN_ADD);
        prog[1][6] = jump_word(6);
        expect_write(1, 1, 32'd3);
        expect_write(1, 2, 32'd6);
        expect_write(1, 3, 32'd9);
        expect_write(1, 4, 32'd109);
        expect_write(1, 5, 32'd103);
        expect_write(1, 6, 32'd206);
        // store, load back, load-use
        prog[2][0] = itype_word(`CPU_OP_ADDI, 1, 0, 32'h55);
        prog[2][1] = itype_word(`CPU_OP_ADDI, 2, 0, -2);
        prog[2][2] = itype_word(`CPU_OP_SW, 1, 0, 8);
        prog[2][3] = itype_word(`CPU_OP_SW, 2, 0, 12);
        prog[2][4] = itype_word(`CPU_OP_LW, 3, 0, 8);
        prog[2][5] = itype_word(`CPU_OP_LW, 4, 0, 12);
        prog[2][6] = rtype_word(5, 4, 3, `CPU_FN_ADD);
        prog[2][7] = jump_word(7);
        expect_write(2, 1, 32'h0000_0055);
        expect_write(2, 2, 32'hffff_fffe);
        expect_write(2, 3, 32'h0000_0055);
        expect_write(2, 4, 32'hffff_fffe);
        expect_write(2, 5, 32'h0000_0053);
        // bne not taken, beq taken over word 6 to word 7
        prog[3][0] = itype_word(`CPU_OP_ADDI, 1, 0, 7);
        prog[3][1] = itype_word(`CPU_OP_BNE, 1, 1, 2);
        prog[3][2] = itype_word(`CPU_OP_ADDI, 2, 0, 32'h11);
        prog[3][3] = itype_word(`CPU_OP_ADDI, 3, 0, 32'h22);
        prog[3][4] = itype_word(`CPU_OP_BEQ, 1, 1, 2);
        prog[3][5] = itype_word(`CPU_OP_ADDI, 4, 0, 32'h44);
        prog[3][6] = itype_word(`CPU_OP_ADDI, 5, 0, 32'h99);
        prog[3][7] = itype_word(`CPU_OP_ADDI, 6, 0, 32'h66);
        prog[3][8] = jump_word(8);
        expect_write(3, 1, 32'h07);
        expect_write(3, 2, 32'h11);
        expect_write(3, 3, 32'h22);
        expect_write(3, 4, 32'h44);
        expect_write(3, 6, 32'h66);
        // jump over a block, then writes to and reads of register 0
        prog[4][0] = itype_word(`CPU_OP_ADDI, 1, 0, 5);
        prog[4][1] = jump_word(4);
        prog[4][2] = itype_word(`CPU_OP_ADDI, 2, 0, 32'h12);
        prog[4][3] = itype_word(`CPU_OP_ADDI, 3, 0, 32'h77);
        prog[4][4] = itype_word(`CPU_OP_ADDI, 0, 0, 32'h3c);
        prog[4][5] = rtype_word(4, 0, 1, `CPU_FN_ADD);
        prog[4][6] = rtype_word(5, 0, 0, `CPU_FN_OR);
        prog[4][7] = jump_word(7);
        expect_write(4, 1, 32'h05);
        expect_write(4, 2, 32'h12);
        expect_write(4, 4, 32'h05);
        expect_write(4, 5, 32'h00);
    endtask

    task automatic run_one(input int t, output logic gave_up);
        int   w;
        int   waited;
        logic finished;
        @(posedge SYS_clk);
        hold <= 1'b1;
        for (w = 0; w < 10; w++)
        begin
            @(posedge SYS_clk);
            load_en   <= 1'b1;
            load_addr <= 6'(w);
            load_data <= prog[t][w];
        end
        @(posedge SYS_clk);
        load_en   <= 1'b0;
        cur_test  <= 3'(t);
        cur_count <= 4'(exp_n[t]);
        for (w = 0; w < 6; w++)
        begin
            cur_reg[w] <= exp_reg[t][w];
            cur_val[w] <= exp_val[t][w];
        end
        @(posedge SYS_clk);
        hold  <= 1'b0;
        start <= 1'b1;
        @(posedge SYS_clk);
        start <= 1'b0;
        finished = 1'b0;
        for (waited = 0; (waited < 400) && !finished; waited++)
        begin
            @(posedge SYS_clk);
            finished = checker_done;
        end
        if (!finished)
            $display("checker gave no result for test %0d within 400 cycles", t);
        gave_up = !finished;
    endtask

    initial
    begin
        hold      = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        report    = 1'b0;
        cur_test  = '0;
        cur_count = '0;
        cur_reg   = '0;
        cur_val   = '0;
        timed_out = 1'b0;
        build_table();
        for (int t = 0; (t < 5) && !timed_out; t++)
            run_one(t, timed_out);
        if (!timed_out)
        begin
            @(posedge SYS_clk);
            report <= 1'b1;
            @(posedge SYS_clk);
            report <= 1'b0;
            @(posedge SYS_clk);
        end
        if (!timed_out && (failed_tests == 0))
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/mips_core.sv
bench/clock_gen.sv
bench/wb_checker.sv
bench/tb_mips_core.sv

//--- run.sh
#!/bin/sh
# builds and runs the testbench with Verilator, exit status follows the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_mips_core -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"
echo "$output" | grep -q "^=== PASS ===$"
